// File: common/ctrl_settings.svh
// ****************************************
// field widths, RISC-V opcode and funct3
// codes, result source code for loads
// ****************************************

`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// field widths
`define CTRL_OP_W  7
`define CTRL_REG_W 5
`define CTRL_F3_W  3

// supported opcodes
`define CTRL_OP_LOAD    7'b0000011
`define CTRL_OP_STORE   7'b0100011
`define CTRL_OP_RTYPE   7'b0110011
`define CTRL_OP_BRANCH  7'b1100011
`define CTRL_OP_ITYPE   7'b0010011
`define CTRL_OP_JAL     7'b1101111
`define CTRL_OP_LUI     7'b0110111
`define CTRL_OP_JALR    7'b1100111

// funct3 codes
`define CTRL_F3_ADDSUB  3'b000
`define CTRL_F3_SLT     3'b010
`define CTRL_F3_OR      3'b110
`define CTRL_F3_AND     3'b111
`define CTRL_F3_BEQ     3'b000
`define CTRL_F3_BNE     3'b001

// result source that marks a load in execute
`define CTRL_RES_LOAD   2'b01

`endif

// File: common/ctrl_pkg.sv
// ****************************************
// shared types of the dual-issue control
// unit: decode inputs, stage controls,
// forwarding selects and hazard flags
// ****************************************

`include "ctrl_settings.svh"

package ctrl_pkg;

   typedef logic [`CTRL_REG_W-1:0] regIdx_t;

   // decode inputs of one slot
   typedef struct packed {
      logic [`CTRL_OP_W-1:0] op;
      logic [`CTRL_F3_W-1:0] funct3;
      logic                  funct7b5;
   } instrFields_t;

   typedef struct packed {
      regIdx_t rs1;
      regIdx_t rs2;
      regIdx_t rd;
   } decodeRegs_t;

   typedef struct packed {
      regIdx_t rs1;
      regIdx_t rs2;
      regIdx_t rd;
   } execRegs_t;

   typedef enum logic [2:0] {
      aluAdd = 3'b000,
      aluSub = 3'b001,
      aluAnd = 3'b010,
      aluOr  = 3'b011,
      aluSlt = 3'b101
   } aluCtrl_e;

   typedef enum logic [1:0] {
      resAlu     = 2'b00,
      resLoad    = `CTRL_RES_LOAD,
      resPcPlus4 = 2'b10,
      resImm     = 2'b11
   } resultSrc_e;

   // full decode word of one slot
   typedef struct packed {
      logic       regWrite;
      logic [2:0] immSrc;
      logic       aluSrc;
      logic       memWrite;
      resultSrc_e resultSrc;
      logic       branch;
      logic       jump;
      logic       branchNe;
      aluCtrl_e   aluControl;
      logic       usesRs2;
   } decodeCtrl_t;

   typedef struct packed {
      aluCtrl_e aluControl;
      logic     aluSrc;
   } execCtrl_t;

   typedef struct packed {
      logic       memWrite;
      resultSrc_e resultSrc;
   } memCtrl_t;

   typedef struct packed {
      logic       regWrite;
      resultSrc_e resultSrc;
   } wbCtrl_t;

   // per-slot view the hazard unit needs
   typedef struct packed {
      resultSrc_e resultSrcE;
      logic       regWriteM;
      logic       regWriteW;
   } slotState_t;

   typedef enum logic [1:0] {
      fwdEx  = 2'd0,
      fwdWb  = 2'd1,
      fwdMem = 2'd2
   } fwdSrc_e;

   typedef struct packed {
      logic    otherSlot;
      fwdSrc_e src;
   } fwdSel_t;

   typedef struct packed {
      logic stallF;
      logic stallD;
      logic flushD;
      logic flushE;
   } slotHazard_t;

   typedef struct packed {
      logic raw;
      logic war;
      logic waw;
   } pairHazard_t;

endpackage

// File: hw/slotControl/slotDecoder.sv
// ****************************************
// decode stage of one slot: main decoder,
// ALU decoder and branch-sense decoder
// ****************************************

`timescale 1ns/100ps

`include "ctrl_settings.svh"

module slotDecoder import ctrl_pkg::*; (
   input  instrFields_t fields_i,
   output decodeCtrl_t  ctrl_o,
   output logic [2:0]   immSrc_o
);

   // ALU class from the main decoder
   localparam logic [1:0] aluOpMem    = 2'b00;
   localparam logic [1:0] aluOpBranch = 2'b01;
   localparam logic [1:0] aluOpFunct  = 2'b10;

   typedef struct packed {
      logic       regWrite;
      logic [2:0] immSrc;
      logic       aluSrc;
      logic       memWrite;
      resultSrc_e resultSrc;
      logic       branch;
      logic [1:0] aluOp;
      logic       jump;
   } mainDec_t;

   mainDec_t mainDec;
   aluCtrl_e aluCtrl;
   logic     rtypeSub;
   logic     branchNe;
   logic     usesRs2;

   // regWrite_immSrc_aluSrc_memWrite_resultSrc_branch_aluOp_jump
   always_comb begin
      case (fields_i.op)
         `CTRL_OP_LOAD:   mainDec = 12'b1_000_1_0_01_0_00_0;
         `CTRL_OP_STORE:  mainDec = 12'b0_001_1_1_00_0_00_0;
         `CTRL_OP_RTYPE:  mainDec = 12'b1_000_0_0_00_0_10_0;
         `CTRL_OP_BRANCH: mainDec = 12'b0_010_0_0_00_1_01_0;
         `CTRL_OP_ITYPE:  mainDec = 12'b1_000_1_0_00_0_10_0;
         `CTRL_OP_JAL:    mainDec = 12'b1_011_0_0_10_0_00_1;
         `CTRL_OP_LUI:    mainDec = 12'b1_100_0_0_11_0_00_0;
         `CTRL_OP_JALR:   mainDec = 12'b1_000_1_0_10_0_00_1;
         // unsupported opcodes leave every control low
         default:         mainDec = '0;
      endcase
   end

   // subtract only for R-type with funct7 bit 5 set
   assign rtypeSub = fields_i.funct7b5 & fields_i.op[5];

   always_comb begin
      case (mainDec.aluOp)
         aluOpBranch: aluCtrl = aluSub;
         aluOpFunct: begin
            case (fields_i.funct3)
               `CTRL_F3_ADDSUB: aluCtrl = rtypeSub ? aluSub : aluAdd;
               `CTRL_F3_SLT:    aluCtrl = aluSlt;
               `CTRL_F3_OR:     aluCtrl = aluOr;
               `CTRL_F3_AND:    aluCtrl = aluAnd;
               default:         aluCtrl = aluAdd;
            endcase
         end
         aluOpMem: aluCtrl = aluAdd;
         default:  aluCtrl = aluAdd;
      endcase
   end

   // bne inverts the zero flag in execute
   assign branchNe = mainDec.branch & (fields_i.funct3 == `CTRL_F3_BNE);

   assign usesRs2 = (fields_i.op == `CTRL_OP_RTYPE) ||
                    (fields_i.op == `CTRL_OP_STORE) ||
                    (fields_i.op == `CTRL_OP_BRANCH);

   assign ctrl_o = '{
      regWrite:   mainDec.regWrite,
      immSrc:     mainDec.immSrc,
      aluSrc:     mainDec.aluSrc,
      memWrite:   mainDec.memWrite,
      resultSrc:  mainDec.resultSrc,
      branch:     mainDec.branch,
      jump:       mainDec.jump,
      branchNe:   branchNe,
      aluControl: aluCtrl,
      usesRs2:    usesRs2
   };

   assign immSrc_o = mainDec.immSrc;

endmodule

// File: hw/slotControl/slotPipe.sv
// ****************************************
// execute, memory and writeback control
// registers of one slot, branch redirect
// ****************************************

`timescale 1ns/100ps

module slotPipe import ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  decodeCtrl_t ctrlD_i,
   input  logic        flushE_i,
   input  logic        zeroE_i,
   output execCtrl_t   execCtrl_o,
   output logic        pcSrcE_o,
   output memCtrl_t    memCtrl_o,
   output wbCtrl_t     wbCtrl_o,
   output slotState_t  state_o
);

   execCtrl_t  execE;
   logic       regWriteE;
   logic       memWriteE;
   resultSrc_e resultSrcE;
   logic       branchE;
   logic       branchNeE;
   logic       jumpE;

   logic       regWriteM;
   memCtrl_t   memM;
   wbCtrl_t    wbW;

   // a flush inserts a bubble into execute
   always_ff @(posedge clk) begin
      if (reset || flushE_i) begin
         execE      <= '0;
         regWriteE  <= 1'b0;
         memWriteE  <= 1'b0;
         resultSrcE <= resAlu;
         branchE    <= 1'b0;
         branchNeE  <= 1'b0;
         jumpE      <= 1'b0;
      end else begin
         execE      <= '{aluControl: ctrlD_i.aluControl, aluSrc: ctrlD_i.aluSrc};
         regWriteE  <= ctrlD_i.regWrite;
         memWriteE  <= ctrlD_i.memWrite;
         resultSrcE <= ctrlD_i.resultSrc;
         branchE    <= ctrlD_i.branch;
         branchNeE  <= ctrlD_i.branchNe;
         jumpE      <= ctrlD_i.jump;
      end
   end

   // memory and writeback only clear on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         regWriteM <= 1'b0;
         memM      <= '0;
         wbW       <= '0;
      end else begin
         regWriteM <= regWriteE;
         memM      <= '{memWrite: memWriteE, resultSrc: resultSrcE};
         wbW       <= '{regWrite: regWriteM, resultSrc: memM.resultSrc};
      end
   end

   // taken branch or any jump redirects fetch
   assign pcSrcE_o = (branchE & (zeroE_i ^ branchNeE)) | jumpE;

   assign execCtrl_o = execE;
   assign memCtrl_o  = memM;
   assign wbCtrl_o   = wbW;

   assign state_o = '{resultSrcE: resultSrcE, regWriteM: regWriteM, regWriteW: wbW.regWrite};

endmodule

// File: hw/hazard/hazardUnit.sv
// ****************************************
// forwarding, load-use stalls, pair
// hazards and stall/flush for both slots
// ****************************************

`timescale 1ns/100ps

module hazardUnit import ctrl_pkg::*; (
   input  decodeCtrl_t ctrlD1_i,
   input  decodeCtrl_t ctrlD2_i,
   input  decodeRegs_t regsD1_i,
   input  decodeRegs_t regsD2_i,
   input  execRegs_t   regsE1_i,
   input  execRegs_t   regsE2_i,
   input  regIdx_t     rdM1_i,
   input  regIdx_t     rdW1_i,
   input  regIdx_t     rdM2_i,
   input  regIdx_t     rdW2_i,
   input  slotState_t  state1_i,
   input  slotState_t  state2_i,
   input  logic        mispredict_i,
   output fwdSel_t     fwdA1_o,
   output fwdSel_t     fwdB1_o,
   output fwdSel_t     fwdA2_o,
   output fwdSel_t     fwdB2_o,
   output slotHazard_t hazard1_o,
   output slotHazard_t hazard2_o,
   output pairHazard_t pair_o
);

   logic lwStall1;
   logic loadUse1;
   logic loadUse2;
   logic hazard2;
   logic flush2;

   // priority runs own mem, own wb, other mem, other wb
   // index zero never forwards
   function automatic fwdSel_t pickFwd(
      input regIdx_t rs,
      input regIdx_t rdOwnM,
      input logic    wrOwnM,
      input regIdx_t rdOwnW,
      input logic    wrOwnW,
      input regIdx_t rdOthM,
      input logic    wrOthM,
      input regIdx_t rdOthW,
      input logic    wrOthW
   );
      fwdSel_t sel;
      sel = '{otherSlot: 1'b0, src: fwdEx};
      if (rs != '0) begin
         if (wrOwnM && (rs == rdOwnM))
            sel = '{otherSlot: 1'b0, src: fwdMem};
         else if (wrOwnW && (rs == rdOwnW))
            sel = '{otherSlot: 1'b0, src: fwdWb};
         else if (wrOthM && (rs == rdOthM))
            sel = '{otherSlot: 1'b1, src: fwdMem};
         else if (wrOthW && (rs == rdOthW))
            sel = '{otherSlot: 1'b1, src: fwdWb};
      end
      return sel;
   endfunction

   assign fwdA1_o = pickFwd(regsE1_i.rs1, rdM1_i, state1_i.regWriteM, rdW1_i,
                            state1_i.regWriteW, rdM2_i, state2_i.regWriteM,
                            rdW2_i, state2_i.regWriteW);
   assign fwdB1_o = pickFwd(regsE1_i.rs2, rdM1_i, state1_i.regWriteM, rdW1_i,
                            state1_i.regWriteW, rdM2_i, state2_i.regWriteM,
                            rdW2_i, state2_i.regWriteW);
   assign fwdA2_o = pickFwd(regsE2_i.rs1, rdM2_i, state2_i.regWriteM, rdW2_i,
                            state2_i.regWriteW, rdM1_i, state1_i.regWriteM,
                            rdW1_i, state1_i.regWriteW);
   assign fwdB2_o = pickFwd(regsE2_i.rs2, rdM2_i, state2_i.regWriteM, rdW2_i,
                            state2_i.regWriteW, rdM1_i, state1_i.regWriteM,
                            rdW1_i, state1_i.regWriteW);

   // pair hazards between the two decoded instructions
   assign pair_o.raw = ctrlD1_i.regWrite && (regsD1_i.rd != '0) &&
                       ((regsD2_i.rs1 == regsD1_i.rd) ||
                        (ctrlD2_i.usesRs2 && (regsD2_i.rs2 == regsD1_i.rd)));
   assign pair_o.war = ctrlD2_i.regWrite && (regsD2_i.rd != '0) &&
                       ((regsD1_i.rs1 == regsD2_i.rd) ||
                        (ctrlD1_i.usesRs2 && (regsD1_i.rs2 == regsD2_i.rd)));
   assign pair_o.waw = ctrlD1_i.regWrite && ctrlD2_i.regWrite &&
                       (regsD1_i.rd == regsD2_i.rd) && (regsD1_i.rd != '0);

   // load in slot 1 execute against either slot's decode
   assign lwStall1 = (state1_i.resultSrcE == resLoad) && (regsE1_i.rd != '0) &&
                     ((regsD1_i.rs1 == regsE1_i.rd) || (regsD1_i.rs2 == regsE1_i.rd));
   assign loadUse1 = (state1_i.resultSrcE == resLoad) && (regsE1_i.rd != '0) &&
                     ((regsD2_i.rs1 == regsE1_i.rd) || (regsD2_i.rs2 == regsE1_i.rd));
   // load in slot 2 execute feeding slot 1
   assign loadUse2 = (state2_i.resultSrcE == resLoad) && (regsE2_i.rd != '0) &&
                     ((regsD1_i.rs1 == regsE2_i.rd) || (regsD1_i.rs2 == regsE2_i.rd));

   assign hazard1_o = '{
      stallF: lwStall1,
      stallD: lwStall1,
      flushD: mispredict_i,
      flushE: lwStall1 | mispredict_i
   };

   assign hazard2 = pair_o.raw || pair_o.waw || loadUse1 || loadUse2;

   // slot 2 also drops its instruction behind a slot 1 branch or jump
   assign flush2 = hazard2 || mispredict_i || ctrlD1_i.branch || ctrlD1_i.jump;

   assign hazard2_o = '{
      stallF: hazard2,
      stallD: hazard2,
      flushD: flush2,
      flushE: flush2
   };

endmodule

// File: hw/dualIssueControl.sv
// ****************************************
// dual-issue control top: two slot
// decoders and pipes, shared hazard unit
// ****************************************

`timescale 1ns/100ps

module dualIssueControl import ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  instrFields_t fields1_i,
   input  instrFields_t fields2_i,
   input  decodeRegs_t regsD1_i,
   input  decodeRegs_t regsD2_i,
   input  execRegs_t   regsE1_i,
   input  execRegs_t   regsE2_i,
   input  regIdx_t     rdM1_i,
   input  regIdx_t     rdW1_i,
   input  regIdx_t     rdM2_i,
   input  regIdx_t     rdW2_i,
   input  logic        zeroE1_i,
   input  logic        zeroE2_i,
   input  logic        mispredict_i,
   output logic [2:0]  immSrc1_o,
   output logic [2:0]  immSrc2_o,
   output execCtrl_t   execCtrl1_o,
   output execCtrl_t   execCtrl2_o,
   output logic        pcSrcE1_o,
   output logic        pcSrcE2_o,
   output memCtrl_t    memCtrl1_o,
   output memCtrl_t    memCtrl2_o,
   output wbCtrl_t     wbCtrl1_o,
   output wbCtrl_t     wbCtrl2_o,
   output fwdSel_t     fwdA1_o,
   output fwdSel_t     fwdB1_o,
   output fwdSel_t     fwdA2_o,
   output fwdSel_t     fwdB2_o,
   output slotHazard_t hazard1_o,
   output slotHazard_t hazard2_o,
   output pairHazard_t pair_o
);

   decodeCtrl_t ctrlD1;
   decodeCtrl_t ctrlD2;
   slotState_t  state1;
   slotState_t  state2;

   // slot 1
   slotDecoder u_decoder1 (
      .fields_i (fields1_i),
      .ctrl_o   (ctrlD1),
      .immSrc_o (immSrc1_o)
   );

   slotPipe u_pipe1 (
      .clk        (clk),
      .reset      (reset),
      .ctrlD_i    (ctrlD1),
      .flushE_i   (hazard1_o.flushE),
      .zeroE_i    (zeroE1_i),
      .execCtrl_o (execCtrl1_o),
      .pcSrcE_o   (pcSrcE1_o),
      .memCtrl_o  (memCtrl1_o),
      .wbCtrl_o   (wbCtrl1_o),
      .state_o    (state1)
   );

   // slot 2
   slotDecoder u_decoder2 (
      .fields_i (fields2_i),
      .ctrl_o   (ctrlD2),
      .immSrc_o (immSrc2_o)
   );

   slotPipe u_pipe2 (
      .clk        (clk),
      .reset      (reset),
      .ctrlD_i    (ctrlD2),
      .flushE_i   (hazard2_o.flushE),
      .zeroE_i    (zeroE2_i),
      .execCtrl_o (execCtrl2_o),
      .pcSrcE_o   (pcSrcE2_o),
      .memCtrl_o  (memCtrl2_o),
      .wbCtrl_o   (wbCtrl2_o),
      .state_o    (state2)
   );

   hazardUnit u_hazardUnit (
      .ctrlD1_i     (ctrlD1),
      .ctrlD2_i     (ctrlD2),
      .regsD1_i     (regsD1_i),
      .regsD2_i     (regsD2_i),
      .regsE1_i     (regsE1_i),
      .regsE2_i     (regsE2_i),
      .rdM1_i       (rdM1_i),
      .rdW1_i       (rdW1_i),
      .rdM2_i       (rdM2_i),
      .rdW2_i       (rdW2_i),
      .state1_i     (state1),
      .state2_i     (state2),
      .mispredict_i (mispredict_i),
      .fwdA1_o      (fwdA1_o),
      .fwdB1_o      (fwdB1_o),
      .fwdA2_o      (fwdA2_o),
      .fwdB2_o      (fwdB2_o),
      .hazard1_o    (hazard1_o),
      .hazard2_o    (hazard2_o),
      .pair_o       (pair_o)
   );

endmodule

// File: tb/dualIssueControl_assertions.sv
// ****************************************
// concurrent checks on stall, flush and
// reset behavior of the control top
// ****************************************

`timescale 1ns/100ps

module dualIssueControl_assertions import ctrl_pkg::*; (
   input logic        clk,
   input logic        reset,
   input logic        mispredict_i,
   input slotHazard_t hazard1_i,
   input slotHazard_t hazard2_i,
   input pairHazard_t pair_i,
   input logic        pcSrcE1_i,
   input logic        pcSrcE2_i,
   input memCtrl_t    memCtrl1_i,
   input memCtrl_t    memCtrl2_i,
   input wbCtrl_t     wbCtrl1_i,
   input wbCtrl_t     wbCtrl2_i
);

   int failCount = 0;

   // a stalled decode always leaves a bubble in execute
   flushWithStall1: assert property (@(posedge clk) disable iff (reset)
      hazard1_i.stallD |-> hazard1_i.flushE)
      else begin
         failCount++;
         $error("slot 1 stalled decode without flushing execute");
      end

   flushWithStall2: assert property (@(posedge clk) disable iff (reset)
      hazard2_i.stallD |-> hazard2_i.flushE)
      else begin
         failCount++;
         $error("slot 2 stalled decode without flushing execute");
      end

   mispredictFlush2: assert property (@(posedge clk) disable iff (reset)
      mispredict_i |-> (hazard2_i.flushD && hazard2_i.flushE))
      else begin
         failCount++;
         $error("slot 2 not flushed on mispredict");
      end

   pairStall2: assert property (@(posedge clk) disable iff (reset)
      (pair_i.raw || pair_i.waw) |-> (hazard2_i.stallF && hazard2_i.stallD))
      else begin
         failCount++;
         $error("slot 2 not stalled on a RAW or WAW pair");
      end

   // one cycle after reset nothing redirects or writes
   resetIdle: assert property (@(posedge clk)
      reset |=> (!pcSrcE1_i && !pcSrcE2_i && !memCtrl1_i.memWrite &&
                 !memCtrl2_i.memWrite && !wbCtrl1_i.regWrite && !wbCtrl2_i.regWrite))
      else begin
         failCount++;
         $error("controls still active after reset");
      end

endmodule

bind dualIssueControl dualIssueControl_assertions u_assertions (
   .clk          (clk),
   .reset        (reset),
   .mispredict_i (mispredict_i),
   .hazard1_i    (hazard1_o),
   .hazard2_i    (hazard2_o),
   .pair_i       (pair_o),
   .pcSrcE1_i    (pcSrcE1_o),
   .pcSrcE2_i    (pcSrcE2_o),
   .memCtrl1_i   (memCtrl1_o),
   .memCtrl2_i   (memCtrl2_o),
   .wbCtrl1_i    (wbCtrl1_o),
   .wbCtrl2_i    (wbCtrl2_o)
);

// File: tb/dualIssueControl_tb.sv
// ****************************************
// testbench of the dual-issue control:
// LFSR stimulus, reference model, shadow
// stage registers, compare and report
// ****************************************

`timescale 1ns/100ps

`include "ctrl_settings.svh"

module dualIssueControl_tb import ctrl_pkg::*; ();

   localparam int resetCycles   = 16;
   localparam int numTests      = 2000;
   localparam int timeoutCycles = 2100;

   logic         clk;
   logic         reset;
   instrFields_t fields [2];
   decodeRegs_t  regsD [2];
   execRegs_t    regsE [2];
   regIdx_t      rdM [2];
   regIdx_t      rdW [2];
   logic         zeroE [2];
   logic         mispredict;

   logic [2:0]   immSrc [2];
   execCtrl_t    execCtrl [2];
   logic         pcSrcE [2];
   memCtrl_t     memCtrl [2];
   wbCtrl_t      wbCtrl [2];
   fwdSel_t      fwdA [2];
   fwdSel_t      fwdB [2];
   slotHazard_t  hazard [2];
   pairHazard_t  pair;

   // shadow of the execute, memory and writeback registers
   decodeCtrl_t  mE [2];
   logic         mRegWrM [2];
   memCtrl_t     mM [2];
   wbCtrl_t      mW [2];

   logic [31:0]  lfsr = 32'hc3e0_f1bd;
   int           resetCount = 0;
   int           testCount = 0;
   int           cycleCount = 0;
   int           checkCount = 0;
   int           errorCount = 0;
   logic         testsDone = 1'b0;
   logic         wasReset = 1'b1;

   dualIssueControl u_dualIssueControl (
      .clk          (clk),
      .reset        (reset),
      .fields1_i    (fields[0]),
      .fields2_i    (fields[1]),
      .regsD1_i     (regsD[0]),
      .regsD2_i     (regsD[1]),
      .regsE1_i     (regsE[0]),
      .regsE2_i     (regsE[1]),
      .rdM1_i       (rdM[0]),
      .rdW1_i       (rdW[0]),
      .rdM2_i       (rdM[1]),
      .rdW2_i       (rdW[1]),
      .zeroE1_i     (zeroE[0]),
      .zeroE2_i     (zeroE[1]),
      .mispredict_i (mispredict),
      .immSrc1_o    (immSrc[0]),
      .immSrc2_o    (immSrc[1]),
      .execCtrl1_o  (execCtrl[0]),
      .execCtrl2_o  (execCtrl[1]),
      .pcSrcE1_o    (pcSrcE[0]),
      .pcSrcE2_o    (pcSrcE[1]),
      .memCtrl1_o   (memCtrl[0]),
      .memCtrl2_o   (memCtrl[1]),
      .wbCtrl1_o    (wbCtrl[0]),
      .wbCtrl2_o    (wbCtrl[1]),
      .fwdA1_o      (fwdA[0]),
      .fwdB1_o      (fwdB[0]),
      .fwdA2_o      (fwdA[1]),
      .fwdB2_o      (fwdB[1]),
      .hazard1_o    (hazard[0]),
      .hazard2_o    (hazard[1]),
      .pair_o       (pair)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] drawBits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrStep(lfsr);
         v = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   // one code in sixteen is a fence, which the decoder does not support
   function automatic logic [`CTRL_OP_W-1:0] pickOp(input logic [3:0] v);
      if (v == 4'hf)
         return 7'b0001111;
      case (v[2:0])
         3'd0:    return `CTRL_OP_LOAD;
         3'd1:    return `CTRL_OP_STORE;
         3'd2:    return `CTRL_OP_RTYPE;
         3'd3:    return `CTRL_OP_BRANCH;
         3'd4:    return `CTRL_OP_ITYPE;
         3'd5:    return `CTRL_OP_JAL;
         3'd6:    return `CTRL_OP_LUI;
         default: return `CTRL_OP_JALR;
      endcase
   endfunction

   task automatic driveSlot(input int s);
      instrFields_t f;
      decodeRegs_t  d;
      execRegs_t    e;
      logic [7:0]   v;
      v = drawBits(4);
      f.op = pickOp(v[3:0]);
      v = drawBits(4);
      f.funct3 = v[2:0];
      f.funct7b5 = v[3];
      // indices 0..3 keep hazards frequent
      d.rs1 = regIdx_t'(drawBits(2));
      d.rs2 = regIdx_t'(drawBits(2));
      d.rd = regIdx_t'(drawBits(2));
      e.rs1 = regIdx_t'(drawBits(2));
      e.rs2 = regIdx_t'(drawBits(2));
      e.rd = regIdx_t'(drawBits(2));
      fields[s] <= f;
      regsD[s] <= d;
      regsE[s] <= e;
      rdM[s] <= regIdx_t'(drawBits(2));
      rdW[s] <= regIdx_t'(drawBits(2));
      v = drawBits(1);
      zeroE[s] <= v[0];
   endtask

   always @(posedge clk) begin
      logic [7:0] v;
      if (resetCount < resetCycles) begin
         resetCount <= resetCount + 1;
         if (resetCount == resetCycles - 1)
            reset <= 1'b0;
      end else if (testCount < numTests) begin
         testCount <= testCount + 1;
         driveSlot(0);
         driveSlot(1);
         v = drawBits(3);
         mispredict <= (v[2:0] == 3'd0);
      end else begin
         testsDone <= 1'b1;
      end
   end

   function automatic decodeCtrl_t ctrlWord(input logic rw, input logic [2:0] imm,
         input logic src, input logic mw, input resultSrc_e res, input logic br,
         input logic jmp);
      decodeCtrl_t d;
      d = '0;
      d.regWrite = rw;
      d.immSrc = imm;
      d.aluSrc = src;
      d.memWrite = mw;
      d.resultSrc = res;
      d.branch = br;
      d.jump = jmp;
      return d;
   endfunction

   // expected decode word from the RISC-V control rules
   function automatic decodeCtrl_t refDecode(input instrFields_t f);
      decodeCtrl_t d;
      logic        isR;
      isR = (f.op == `CTRL_OP_RTYPE);
      case (f.op)
         `CTRL_OP_LOAD:   d = ctrlWord(1'b1, 3'd0, 1'b1, 1'b0, resLoad, 1'b0, 1'b0);
         `CTRL_OP_STORE:  d = ctrlWord(1'b0, 3'd1, 1'b1, 1'b1, resAlu, 1'b0, 1'b0);
         `CTRL_OP_RTYPE:  d = ctrlWord(1'b1, 3'd0, 1'b0, 1'b0, resAlu, 1'b0, 1'b0);
         `CTRL_OP_BRANCH: d = ctrlWord(1'b0, 3'd2, 1'b0, 1'b0, resAlu, 1'b1, 1'b0);
         `CTRL_OP_ITYPE:  d = ctrlWord(1'b1, 3'd0, 1'b1, 1'b0, resAlu, 1'b0, 1'b0);
         `CTRL_OP_JAL:    d = ctrlWord(1'b1, 3'd3, 1'b0, 1'b0, resPcPlus4, 1'b0, 1'b1);
         `CTRL_OP_LUI:    d = ctrlWord(1'b1, 3'd4, 1'b0, 1'b0, resImm, 1'b0, 1'b0);
         `CTRL_OP_JALR:   d = ctrlWord(1'b1, 3'd0, 1'b1, 1'b0, resPcPlus4, 1'b0, 1'b1);
         default:         d = '0;
      endcase
      if (d.branch) begin
         d.aluControl = aluSub;
      end else if (isR || (f.op == `CTRL_OP_ITYPE)) begin
         case (f.funct3)
            `CTRL_F3_ADDSUB: d.aluControl = (isR && f.funct7b5) ? aluSub : aluAdd;
            `CTRL_F3_SLT:    d.aluControl = aluSlt;
            `CTRL_F3_OR:     d.aluControl = aluOr;
            `CTRL_F3_AND:    d.aluControl = aluAnd;
            default:         d.aluControl = aluAdd;
         endcase
      end
      d.branchNe = d.branch && (f.funct3 == `CTRL_F3_BNE);
      d.usesRs2 = isR || (f.op == `CTRL_OP_STORE) || (f.op == `CTRL_OP_BRANCH);
      return d;
   endfunction

   // lowest priority first so that stronger candidates overwrite it
   function automatic fwdSel_t refFwd(input regIdx_t rs, input int own);
      fwdSel_t sel;
      int      oth;
      oth = 1 - own;
      sel = '0;
      if (rs != '0) begin
         if (mW[oth].regWrite && (rs == rdW[oth]))
            sel = '{otherSlot: 1'b1, src: fwdWb};
         if (mRegWrM[oth] && (rs == rdM[oth]))
            sel = '{otherSlot: 1'b1, src: fwdMem};
         if (mW[own].regWrite && (rs == rdW[own]))
            sel = '{otherSlot: 1'b0, src: fwdWb};
         if (mRegWrM[own] && (rs == rdM[own]))
            sel = '{otherSlot: 1'b0, src: fwdMem};
      end
      return sel;
   endfunction

   function automatic logic readsReg(input decodeRegs_t d, input regIdx_t r);
      return (d.rs1 == r) || (d.rs2 == r);
   endfunction

   function automatic void refHazards(input decodeCtrl_t c1, input decodeCtrl_t c2,
         output slotHazard_t h1, output slotHazard_t h2, output pairHazard_t p);
      logic load1;
      logic load2;
      logic own1;
      logic stall2;
      logic flush2;
      p.raw = c1.regWrite && (regsD[0].rd != '0) && ((regsD[1].rs1 == regsD[0].rd) ||
              (c2.usesRs2 && (regsD[1].rs2 == regsD[0].rd)));
      p.war = c2.regWrite && (regsD[1].rd != '0) && ((regsD[0].rs1 == regsD[1].rd) ||
              (c1.usesRs2 && (regsD[0].rs2 == regsD[1].rd)));
      p.waw = c1.regWrite && c2.regWrite && (regsD[0].rd == regsD[1].rd) &&
              (regsD[0].rd != '0);
      load1 = (mE[0].resultSrc == resLoad) && (regsE[0].rd != '0);
      load2 = (mE[1].resultSrc == resLoad) && (regsE[1].rd != '0);
      own1 = load1 && readsReg(regsD[0], regsE[0].rd);
      stall2 = p.raw || p.waw || (load1 && readsReg(regsD[1], regsE[0].rd)) ||
               (load2 && readsReg(regsD[0], regsE[1].rd));
      flush2 = stall2 || mispredict || c1.branch || c1.jump;
      h1 = '{stallF: own1, stallD: own1, flushD: mispredict, flushE: own1 || mispredict};
      h2 = '{stallF: stall2, stallD: stall2, flushD: flush2, flushE: flush2};
   endfunction

   task automatic checkDecode(input string name, input logic [2:0] got, input logic [2:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkExec(input string name, input execCtrl_t got, input execCtrl_t exp,
         input logic gotPc, input logic expPc);
      checkCount++;
      if ((got !== exp) || (gotPc !== expPc)) begin
         errorCount++;
         $display("Error %s: got %h pcSrcE %h, expected %h pcSrcE %h",
                  name, got, gotPc, exp, expPc);
      end
   endtask

   task automatic checkMem(input string name, input memCtrl_t got, input memCtrl_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkWb(input string name, input wbCtrl_t got, input wbCtrl_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkFwd(input string name, input fwdSel_t got, input fwdSel_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkHazard(input string name, input slotHazard_t got,
         input slotHazard_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic checkPair(input string name, input pairHazard_t got, input pairHazard_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // compare on the falling edge, then step the shadow registers
   always @(negedge clk) begin
      decodeCtrl_t dec [2];
      slotHazard_t expH [2];
      pairHazard_t expP;
      execCtrl_t   expE;
      logic        expPc;
      dec[0] = refDecode(fields[0]);
      dec[1] = refDecode(fields[1]);
      refHazards(dec[0], dec[1], expH[0], expH[1], expP);
      if (!reset) begin
         for (int s = 0; s < 2; s++) begin
            // right after reset every registered control must read idle
            if (wasReset) begin
               checkExec($sformatf("idle execCtrl%0d", s + 1), execCtrl[s], '0, pcSrcE[s], 1'b0);
               checkMem($sformatf("idle memCtrl%0d", s + 1), memCtrl[s], '0);
               checkWb($sformatf("idle wbCtrl%0d", s + 1), wbCtrl[s], '0);
               checkFwd($sformatf("idle fwdA%0d", s + 1), fwdA[s], '0);
               checkFwd($sformatf("idle fwdB%0d", s + 1), fwdB[s], '0);
            end
            expE = '{aluControl: mE[s].aluControl, aluSrc: mE[s].aluSrc};
            expPc = (mE[s].branch && (zeroE[s] ^ mE[s].branchNe)) || mE[s].jump;
            checkDecode($sformatf("immSrc%0d", s + 1), immSrc[s], dec[s].immSrc);
            checkExec($sformatf("execCtrl%0d", s + 1), execCtrl[s], expE, pcSrcE[s], expPc);
            checkMem($sformatf("memCtrl%0d", s + 1), memCtrl[s], mM[s]);
            checkWb($sformatf("wbCtrl%0d", s + 1), wbCtrl[s], mW[s]);
            checkFwd($sformatf("fwdA%0d", s + 1), fwdA[s], refFwd(regsE[s].rs1, s));
            checkFwd($sformatf("fwdB%0d", s + 1), fwdB[s], refFwd(regsE[s].rs2, s));
            checkHazard($sformatf("hazard%0d", s + 1), hazard[s], expH[s]);
         end
         checkPair("pair", pair, expP);
      end
      wasReset = reset;
      for (int s = 0; s < 2; s++) begin
         if (reset) begin
            mW[s] = '0;
            mM[s] = '0;
            mRegWrM[s] = 1'b0;
            mE[s] = '0;
         end else begin
            mW[s] = '{regWrite: mRegWrM[s], resultSrc: mM[s].resultSrc};
            mM[s] = '{memWrite: mE[s].memWrite, resultSrc: mE[s].resultSrc};
            mRegWrM[s] = mE[s].regWrite;
            if (expH[s].flushE)
               mE[s] = '0;
            else
               mE[s] = dec[s];
         end
      end
   end

   initial begin
      while (cycleCount < timeoutCycles) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("timeout: tests still running after %0d cycles", timeoutCycles);
      $display("Regression failed");
      $finish;
   end

   initial begin
      int assertFails;
      reset = 1'b1;
      mispredict = 1'b0;
      for (int s = 0; s < 2; s++) begin
         // a jump and nonzero indices wait on the inputs through reset
         fields[s] = '{op: `CTRL_OP_JAL, funct3: 3'd0, funct7b5: 1'b0};
         regsD[s] = '0;
         regsE[s] = '{rs1: 5'd1, rs2: 5'd2, rd: 5'd0};
         rdM[s] = 5'd1;
         rdW[s] = 5'd2;
         zeroE[s] = 1'b0;
         mE[s] = '0;
         mRegWrM[s] = 1'b0;
         mM[s] = '0;
         mW[s] = '0;
      end
      wait (testsDone);
      repeat (2) @(negedge clk);
      @(posedge clk);
      #1;
      assertFails = u_dualIssueControl.u_assertions.failCount;
      $display("checks %0d, value errors %0d, assertion failures %0d",
               checkCount, errorCount, assertFails);
      if ((errorCount == 0) && (assertFails == 0) && (checkCount > 0)) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+common
common/ctrl_pkg.sv
hw/slotControl/slotDecoder.sv
hw/slotControl/slotPipe.sv
hw/hazard/hazardUnit.sv
hw/dualIssueControl.sv
tb/dualIssueControl_assertions.sv
tb/dualIssueControl_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := dualIssueControl_tb
FILELIST  := project.f
SIMFLAGS  := +verilator+error+limit+100

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/ctrl_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIMFLAGS) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
